//--- bench/ps2_kbd_chk.sv
`timescale 1ns/100ps

module ps2_kbd_chk (
    input logic        clk,
    input logic        rst,
    input logic        code_valid,
    input logic        frame_err,
    input logic        count_clr,
    input logic [3:0]  an,
    input logic [7:0]  paddr,
    input logic        psel,
    input logic        penable,
    input logic [31:0] prdata
);

    logic fail_excl  = 1'b0;
    logic fail_clr   = 1'b0;
    logic fail_an    = 1'b0;
    logic fail_unmap = 1'b0;
    logic failed;
    logic mapped;

    assign mapped = paddr == ps2_pkg::addr_code || paddr == ps2_pkg::addr_ascii ||
                    paddr == ps2_pkg::addr_status || paddr == ps2_pkg::addr_count ||
                    paddr == ps2_pkg::addr_ctrl;
    assign failed = fail_excl || fail_clr || fail_an || fail_unmap;

    good_or_bad_frame: assert property (@(posedge clk) disable iff (!rst)
        !(code_valid && frame_err))
        else begin
            $error("code_valid and frame_err high in the same cycle");
            fail_excl = 1'b1;
        end

    clear_is_pulse: assert property (@(posedge clk) disable iff (!rst)
        count_clr |=> !count_clr)
        else begin
            $error("count_clr held high for two cycles");
            fail_clr = 1'b1;
        end

    one_digit_lit: assert property (@(posedge clk) disable iff (!rst) $onehot0(~an))
        else begin
            $error("More than one digit enable is low");
            fail_an = 1'b1;
        end

    unmapped_reads_zero: assert property (@(posedge clk) disable iff (!rst)
        (psel && penable && !mapped) |-> prdata == 32'h0)
        else begin
            $error("Unmapped address returned nonzero read data");
            fail_unmap = 1'b1;
        end

endmodule

bind ps2_kbd_top ps2_kbd_chk u_chk (
    .clk        (clk),
    .rst        (rst),
    .code_valid (code_valid),
    .frame_err  (frame_err),
    .count_clr  (count_clr),
    .an         (an),
    .paddr      (paddr),
    .psel       (psel),
    .penable    (penable),
    .prdata     (prdata)
);

//--- bench/ps2_kbd_tb.sv
`timescale 1ns/100ps

module ps2_kbd_tb;

    localparam int n_tests        = 11;
    localparam int scan_div       = 16;
    localparam int half_period    = 20;
    localparam int timeout_cycles = n_tests * 4 * 500 + 10000;

    typedef struct packed {
        logic [2:0]  len;
        logic [31:0] codes;      // First code sits in the top byte
        logic        bad_par;    // Flips the parity bit of every frame in the row
        logic [3:0]  pre_wr;     // Written to the control register before the codes, 0 for none
        logic [7:0]  exp_code;
        logic [7:0]  exp_ascii;
        logic [7:0]  exp_status;
        logic [7:0]  exp_count;
    } test_row_t;

    // Rows run in order and each one starts from the state the rows before it left
    string test_name [n_tests] = '{
        "press_a", "release_a", "shift_letter", "shift_digit", "shift_release",
        "ctrl_press", "ctrl_release", "bad_parity", "unmapped", "count_clear", "press_z"
    };
    test_row_t tests [n_tests] = '{
        '{3'd1, 32'h1C000000, 1'b0, 4'h0, 8'h1C, 8'h61, 8'h01, 8'h00},
        '{3'd2, 32'hF01C0000, 1'b0, 4'h0, 8'h1C, 8'h61, 8'h00, 8'h01},
        '{3'd2, 32'h121B0000, 1'b0, 4'h0, 8'h1B, 8'h53, 8'h03, 8'h01},
        '{3'd3, 32'hF01B1600, 1'b0, 4'h0, 8'h16, 8'h31, 8'h03, 8'h02},
        '{3'd4, 32'hF012F016, 1'b0, 4'h0, 8'h16, 8'h31, 8'h00, 8'h04},
        '{3'd1, 32'h14000000, 1'b0, 4'h0, 8'h16, 8'h31, 8'h04, 8'h04},
        '{3'd2, 32'hF0140000, 1'b0, 4'h0, 8'h16, 8'h31, 8'h00, 8'h05},
        '{3'd1, 32'h2C000000, 1'b1, 4'h0, 8'h16, 8'h31, 8'h08, 8'h05},
        '{3'd1, 32'h05000000, 1'b0, 4'h5, 8'h05, 8'h00, 8'h01, 8'h05},
        '{3'd2, 32'hF0050000, 1'b0, 4'h3, 8'h05, 8'h00, 8'h00, 8'h01},
        '{3'd1, 32'h1A000000, 1'b0, 4'h0, 8'h1A, 8'h7A, 8'h01, 8'h01}
    };

    // Lit segments in gfedcba order for hex digits 0 to F
    localparam logic [6:0] lit_segs [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };

    logic        clk;
    logic        rst;
    logic        ps2_clk;
    logic        ps2_data;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic [6:0]  seg;
    logic [3:0]  an;
    integer      seed = 32'h2f2b;
    int          cycle_cnt = 0;

    ps2_kbd_top #(
        .filter_len (4),
        .scan_div   (scan_div)
    ) u_dut (
        .clk      (clk),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .seg      (seg),
        .an       (an)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(negedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("Run timed out after %0d cycles", cycle_cnt);
            $display("TEST FAIL");
            $fatal(1, "Timeout");
        end else if (u_dut.u_chk.failed) begin
            $display("A bound assertion on the DUT failed");
            $display("TEST FAIL");
            $fatal(1, "Assertion failure");
        end
    end

    task automatic expect_equal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %0h actual %0h", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic send_frame(input logic [7:0] data, input logic bad_par);
        logic [10:0] bits;
        int          gap;
        bits = {1'b1, ~(^data) ^ bad_par, data, 1'b0}; // Stop, odd parity, data, start
        for (int i = 0; i < 11; i++) begin
            ps2_data = bits[i];
            repeat (half_period) @(negedge clk);
            ps2_clk = 1'b0;
            repeat (half_period) @(negedge clk);
            ps2_clk = 1'b1;
        end
        gap = half_period + ($random(seed) & 63);
        repeat (gap) @(negedge clk);
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(negedge clk);
        paddr  = addr;
        pwdata = data;
        pwrite = 1'b1;
        psel   = 1'b1;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        @(negedge clk);
        paddr  = addr;
        pwrite = 1'b0;
        psel   = 1'b1;
        @(negedge clk);
        penable = 1'b1;
        data    = prdata; // Access cycle starts here
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_blank(input string name, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            expect_equal(name, 32'hF, {28'b0, an});
        end
    endtask

    task automatic check_scan(input logic [7:0] code_v, input logic [7:0] ascii_v);
        logic [15:0] word;
        logic [3:0]  seen;
        logic [3:0]  nib;
        word = {code_v, ascii_v};
        seen = 4'h0;
        repeat (8 * scan_div) begin
            @(negedge clk);
            for (int k = 0; k < 4; k++) begin
                if (an == ~(4'b0001 << k)) begin
                    nib     = word[4*k +: 4];
                    seen[k] = 1'b1;
                    expect_equal("scan_seg", {25'b0, ~lit_segs[nib]}, {25'b0, seg});
                end
            end
        end
        expect_equal("scan_digits", 32'hF, {28'b0, seen});
    endtask

    initial begin
        logic [31:0] rd;
        rst      = 1'b0;
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
        paddr    = 8'h00;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        pwdata   = 32'h0;
        repeat (2) @(negedge clk);
        rst = 1'b1;
        check_blank("blank_before_key", 8 * scan_div);
        for (int t = 0; t < n_tests; t++) begin
            if (tests[t].pre_wr != 4'h0) begin
                apb_write(ps2_pkg::addr_ctrl, {28'b0, tests[t].pre_wr});
            end
            for (int i = 0; i < int'(tests[t].len); i++) begin
                send_frame(tests[t].codes[31 - 8*i -: 8], tests[t].bad_par);
            end
            repeat (20) @(negedge clk);
            apb_read(ps2_pkg::addr_code, rd);
            expect_equal({test_name[t], " code"}, {24'b0, tests[t].exp_code}, rd);
            apb_read(ps2_pkg::addr_ascii, rd);
            expect_equal({test_name[t], " ascii"}, {24'b0, tests[t].exp_ascii}, rd);
            apb_read(ps2_pkg::addr_status, rd);
            expect_equal({test_name[t], " status"}, {24'b0, tests[t].exp_status}, rd);
            apb_read(ps2_pkg::addr_count, rd);
            expect_equal({test_name[t], " count"}, {24'b0, tests[t].exp_count}, rd);
        end
        check_scan(tests[n_tests-1].exp_code, tests[n_tests-1].exp_ascii);
        apb_write(ps2_pkg::addr_ctrl, 32'h0); // Display off
        apb_read(ps2_pkg::addr_ctrl, rd);
        expect_equal("display_off_ctrl", 32'h0, rd);
        check_blank("blank_display_off", 8 * scan_div);
        apb_read(8'h14, rd);
        expect_equal("unmapped_read", 32'h0, rd);
        if (u_dut.u_chk.failed) begin
            $display("A bound assertion on the DUT failed");
            $display("TEST FAIL");
            $fatal(1, "Assertion failure");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

//--- compile.f
source/ps2_pkg.sv
source/ps2_receiver.sv
source/key_decoder.sv
source/seg_scan.sv
source/kbd_apb_regs.sv
source/ps2_kbd_top.sv
bench/ps2_kbd_chk.sv
bench/ps2_kbd_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module ps2_kbd_tb -f compile.f -o ps2_kbd_sim

status=0
out=$(./obj_dir/ps2_kbd_sim 2>&1) || status=$?
echo "$out"

if echo "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
echo "Simulation did not pass (exit status $status)"
exit 1

//--- source/kbd_apb_regs.sv
`timescale 1ns/100ps

module kbd_apb_regs (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    input  logic [7:0]  last_code,
    input  logic [7:0]  ascii,
    input  logic [7:0]  break_count,
    input  logic        shift_flag,
    input  logic        ctrl_flag,
    input  logic        key_held,
    input  logic        frame_err,
    output logic [31:0] prdata,
    output logic        display_on,
    output logic        count_clr
);

    logic ctrl_wr;
    logic err_sticky;

    assign ctrl_wr = psel && penable && pwrite && paddr == ps2_pkg::addr_ctrl;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            display_on <= 1'b1;
            count_clr  <= 1'b0;
        end else begin
            count_clr <= ctrl_wr && pwdata[1];
            if (ctrl_wr) begin
                display_on <= pwdata[0];
            end
        end
    end

    // A frame error in the same cycle as the clear still gets recorded
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            err_sticky <= 1'b0;
        end else if (frame_err) begin
            err_sticky <= 1'b1;
        end else if (ctrl_wr && pwdata[2]) begin
            err_sticky <= 1'b0;
        end
    end

    always_comb begin
        case (paddr)
            ps2_pkg::addr_code:   prdata = {24'b0, last_code};
            ps2_pkg::addr_ascii:  prdata = {24'b0, ascii};
            ps2_pkg::addr_status: prdata = {28'b0, err_sticky, ctrl_flag, shift_flag, key_held};
            ps2_pkg::addr_count:  prdata = {24'b0, break_count};
            ps2_pkg::addr_ctrl:   prdata = {31'b0, display_on};
            default:              prdata = 32'b0;
        endcase
    end

endmodule

//--- source/key_decoder.sv
`timescale 1ns/100ps

module key_decoder (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] code,
    input  logic       code_valid,
    input  logic       count_clr,
    output logic [7:0] last_code,
    output logic [7:0] ascii,
    output logic [7:0] break_count,
    output logic       shift_flag,
    output logic       ctrl_flag,
    output logic       key_held,
    output logic       shown
);

    localparam logic [2:0] st_idle          = 3'b001;
    localparam logic [2:0] st_make          = 3'b010;
    localparam logic [2:0] st_break_pending = 3'b100;

    logic [2:0] state;
    logic       is_break;
    logic       is_shift;
    logic       is_ctrl;

    assign is_break = code == ps2_pkg::code_break;
    assign is_shift = code == ps2_pkg::code_lshift || code == ps2_pkg::code_rshift;
    assign is_ctrl  = code == ps2_pkg::code_ctrl;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= st_idle;
            shift_flag <= 1'b0;
            ctrl_flag  <= 1'b0;
            key_held   <= 1'b0;
            shown      <= 1'b0;
            last_code  <= '0;
            ascii      <= '0;
        end else if (code_valid) begin
            case (state)
                st_break_pending: begin
                    if (is_break) begin
                        state <= st_break_pending;
                    end else begin
                        state <= st_idle; // This code names the released key
                        if (is_shift) begin
                            shift_flag <= 1'b0;
                        end else if (is_ctrl) begin
                            ctrl_flag <= 1'b0;
                        end else begin
                            key_held <= 1'b0;
                        end
                    end
                end
                default: begin
                    if (is_break) begin
                        state <= st_break_pending;
                    end else if (is_shift) begin
                        state      <= st_make;
                        shift_flag <= 1'b1;
                    end else if (is_ctrl) begin
                        state     <= st_make;
                        ctrl_flag <= 1'b1;
                    end else begin
                        state     <= st_make;
                        key_held  <= 1'b1;
                        shown     <= 1'b1;
                        last_code <= code;
                        ascii     <= ps2_pkg::scan_to_ascii(code, shift_flag);
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            break_count <= '0;
        end else if (count_clr) begin
            break_count <= '0;
        end else if (code_valid && is_break) begin
            break_count <= break_count + 8'd1; // Wraps after 255 releases
        end
    end

endmodule

//--- source/ps2_kbd_top.sv
`timescale 1ns/100ps

module ps2_kbd_top #(
    parameter int filter_len = 4,
    parameter int scan_div   = 16
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        ps2_clk,
    input  logic        ps2_data,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic [6:0]  seg,
    output logic [3:0]  an
);

    logic [7:0] code;
    logic       code_valid;
    logic       frame_err;
    logic [7:0] last_code;
    logic [7:0] ascii;
    logic [7:0] break_count;
    logic       shift_flag;
    logic       ctrl_flag;
    logic       key_held;
    logic       shown;
    logic       count_clr;
    logic       display_on;

    ps2_receiver #(
        .filter_len (filter_len)
    ) u_receiver (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .code       (code),
        .code_valid (code_valid),
        .frame_err  (frame_err)
    );

    key_decoder u_decoder (
        .clk         (clk),
        .rst         (rst),
        .code        (code),
        .code_valid  (code_valid),
        .count_clr   (count_clr),
        .last_code   (last_code),
        .ascii       (ascii),
        .break_count (break_count),
        .shift_flag  (shift_flag),
        .ctrl_flag   (ctrl_flag),
        .key_held    (key_held),
        .shown       (shown)
    );

    seg_scan #(
        .scan_div (scan_div)
    ) u_seg_scan (
        .clk        (clk),
        .rst        (rst),
        .last_code  (last_code),
        .ascii      (ascii),
        .shown      (shown),
        .display_on (display_on),
        .seg        (seg),
        .an         (an)
    );

    kbd_apb_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .last_code   (last_code),
        .ascii       (ascii),
        .break_count (break_count),
        .shift_flag  (shift_flag),
        .ctrl_flag   (ctrl_flag),
        .key_held    (key_held),
        .frame_err   (frame_err),
        .prdata      (prdata),
        .display_on  (display_on),
        .count_clr   (count_clr)
    );

endmodule

//--- source/ps2_pkg.sv
package ps2_pkg;

    localparam logic [7:0] code_break  = 8'hF0;
    localparam logic [7:0] code_lshift = 8'h12;
    localparam logic [7:0] code_rshift = 8'h59;
    localparam logic [7:0] code_ctrl   = 8'h14;

    localparam logic [7:0] addr_code   = 8'h00;
    localparam logic [7:0] addr_ascii  = 8'h04;
    localparam logic [7:0] addr_status = 8'h08;
    localparam logic [7:0] addr_count  = 8'h0C;
    localparam logic [7:0] addr_ctrl   = 8'h10;

    function automatic logic [7:0] scan_to_ascii(input logic [7:0] scan, input logic shift);
        logic [7:0] lower;
        case (scan)
            8'h45: lower = 8'h30;
            8'h16: lower = 8'h31;
            8'h1E: lower = 8'h32;
            8'h26: lower = 8'h33;
            8'h25: lower = 8'h34;
            8'h2E: lower = 8'h35;
            8'h36: lower = 8'h36;
            8'h3D: lower = 8'h37;
            8'h3E: lower = 8'h38;
            8'h46: lower = 8'h39;
            8'h1C: lower = 8'h61;
            8'h32: lower = 8'h62;
            8'h21: lower = 8'h63;
            8'h23: lower = 8'h64;
            8'h24: lower = 8'h65;
            8'h2B: lower = 8'h66;
            8'h34: lower = 8'h67;
            8'h33: lower = 8'h68;
            8'h43: lower = 8'h69;
            8'h3B: lower = 8'h6A;
            8'h42: lower = 8'h6B;
            8'h4B: lower = 8'h6C;
            8'h3A: lower = 8'h6D;
            8'h31: lower = 8'h6E;
            8'h44: lower = 8'h6F;
            8'h4D: lower = 8'h70;
            8'h15: lower = 8'h71;
            8'h2D: lower = 8'h72;
            8'h1B: lower = 8'h73;
            8'h2C: lower = 8'h74;
            8'h3C: lower = 8'h75;
            8'h2A: lower = 8'h76;
            8'h1D: lower = 8'h77;
            8'h22: lower = 8'h78;
            8'h35: lower = 8'h79;
            8'h1A: lower = 8'h7A;
            default: lower = 8'h00;
        endcase
        if (shift && lower >= 8'h61) begin // Only letters have an upper case form
            return lower - 8'h20;
        end
        return lower;
    endfunction

    function automatic logic [6:0] hex_to_seg(input logic [3:0] nibble);
        case (nibble) // Segments gfedcba, a lit segment is 0
            4'h0: return 7'h40;
            4'h1: return 7'h79;
            4'h2: return 7'h24;
            4'h3: return 7'h30;
            4'h4: return 7'h19;
            4'h5: return 7'h12;
            4'h6: return 7'h02;
            4'h7: return 7'h78;
            4'h8: return 7'h00;
            4'h9: return 7'h10;
            4'hA: return 7'h08;
            4'hB: return 7'h03;
            4'hC: return 7'h46;
            4'hD: return 7'h21;
            4'hE: return 7'h06;
            default: return 7'h0E;
        endcase
    endfunction

endpackage

//--- source/ps2_receiver.sv
`timescale 1ns/100ps

module ps2_receiver #(
    parameter int filter_len = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic [7:0] code,
    output logic       code_valid,
    output logic       frame_err
);

    localparam int cnt_w      = $clog2(filter_len) + 1;
    localparam int idle_limit = 2000;

    logic [1:0]       clk_sync;
    logic [1:0]       data_sync;
    logic [1:0]       line_in;   // Bit 0 is the clock line, bit 1 the data line
    logic [1:0]       line_filt;
    logic [1:0]       line_upd;
    logic [cnt_w-1:0] filt_cnt [2];
    logic             fall;
    logic [3:0]       bit_cnt;
    logic [9:0]       shreg;
    logic [10:0]      idle_cnt;
    logic             frame_ok;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    assign line_in = {data_sync[1], clk_sync[1]};

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            line_upd[i] = (line_in[i] != line_filt[i]) &&
                          (filt_cnt[i] == cnt_w'(filter_len - 1));
        end
    end

    // A new level must persist for filter_len samples before it is taken
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            line_filt <= 2'b11;
            for (int i = 0; i < 2; i++) begin
                filt_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (line_in[i] == line_filt[i]) begin
                    filt_cnt[i] <= '0;
                end else if (line_upd[i]) begin
                    filt_cnt[i]  <= '0;
                    line_filt[i] <= line_in[i];
                end else begin
                    filt_cnt[i] <= filt_cnt[i] + 1'b1;
                end
            end
        end
    end

    assign fall = line_upd[0] && !line_in[0];

    // On the stop bit shreg holds start in bit 0, data in 8:1 and parity in bit 9
    assign frame_ok = !shreg[0] && line_filt[1] && (^shreg[9:1]);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            bit_cnt    <= '0;
            idle_cnt   <= '0;
            code_valid <= 1'b0;
            frame_err  <= 1'b0;
        end else begin
            code_valid <= 1'b0;
            frame_err  <= 1'b0;
            if (fall) begin
                idle_cnt <= '0;
                if (bit_cnt == 4'd10) begin
                    bit_cnt    <= '0;
                    code_valid <= frame_ok;
                    frame_err  <= !frame_ok;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else if (bit_cnt != 4'd0) begin
                if (idle_cnt == 11'(idle_limit - 1)) begin // Keyboard went quiet mid frame
                    bit_cnt  <= '0;
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fall) begin
            shreg <= {line_filt[1], shreg[9:1]};
        end
        if (fall && bit_cnt == 4'd10 && frame_ok) begin
            code <= shreg[8:1];
        end
    end

endmodule

//--- source/seg_scan.sv
`timescale 1ns/100ps

module seg_scan #(
    parameter int scan_div = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] last_code,
    input  logic [7:0] ascii,
    input  logic       shown,
    input  logic       display_on,
    output logic [6:0] seg,
    output logic [3:0] an
);

    localparam int div_w = (scan_div > 1) ? $clog2(scan_div) : 1;

    logic [div_w-1:0] div_cnt;
    logic [1:0]       digit;
    logic [3:0]       nibble;
    logic             blank;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            div_cnt <= '0;
            digit   <= '0;
        end else if (div_cnt == div_w'(scan_div - 1)) begin
            div_cnt <= '0;
            digit   <= digit + 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Left pair holds the scan code, right pair its ASCII value
    always_comb begin
        case (digit)
            2'd0: nibble = ascii[3:0];
            2'd1: nibble = ascii[7:4];
            2'd2: nibble = last_code[3:0];
            default: nibble = last_code[7:4];
        endcase
    end

    assign blank = !display_on || !shown;

    always_comb begin
        if (blank) begin
            an  = 4'b1111;
            seg = 7'h7F;
        end else begin
            an  = ~(4'b0001 << digit);
            seg = ps2_pkg::hex_to_seg(nibble);
        end
    end

endmodule
